/* Bender.yml */
package:
  name: realign

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/realign_pkg.sv
      - verilog/stream_fifo.sv
      - verilog/realign_cmd_decode.sv
      - verilog/realign_shift_exec.sv
      - verilog/realign_top.sv

  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/tb_realign_top.sv

/* all.f */
+incdir+verilog
verilog/realign_pkg.sv
verilog/stream_fifo.sv
verilog/realign_cmd_decode.sv
verilog/realign_shift_exec.sv
verilog/realign_top.sv
dv/tb_realign_top.sv

/* dv/tb_realign_top.sv */
// realigner testbench
`timescale 1ns/1ps
`include "realign_consts.svh"

module tb_realign_top;

  localparam int NB      = `REALIGN_NB;
  localparam int TIMEOUT = 200;
  localparam int N_ROWS  = 16;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      cmd_valid_i;
  logic                      cmd_ready_o;
  logic [`REALIGN_OFF_W-1:0] cmd_off_i;
  logic [`REALIGN_LEN_W-1:0] cmd_len_i;
  logic                      in_valid_i;
  logic                      in_ready_o;
  logic [`REALIGN_DW-1:0]    in_data_i;
  logic                      out_valid_o;
  logic                      out_ready_i;
  logic [`REALIGN_DW-1:0]    out_data_o;
  logic [NB-1:0]             out_strb_o;
  logic                      out_last_o;

  // offset, length, random stall, then expected output beats and input words
  int row_off   [N_ROWS] = '{0, 0, 1, 2, 3, 0, 3, 2, 0, 3, 1, 2, 3, 0, 1, 2};
  int row_len   [N_ROWS] = '{16, 8, 8, 7, 5, 1, 1, 1, 64, 64, 13, 6, 2, 12, 64, 3};
  bit row_rand  [N_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 0};
  int row_beats [N_ROWS] = '{4, 2, 3, 3, 2, 1, 1, 1, 16, 17, 4, 2, 2, 3, 17, 2};
  int row_words [N_ROWS] = '{4, 2, 2, 2, 2, 1, 1, 1, 16, 16, 4, 2, 1, 3, 16, 1};

  logic [31:0]   exp_data [$];
  logic [NB-1:0] exp_strb [$];
  logic          exp_last [$];
  int            exp_cnt  [$];

  int          errors;
  bit          timed_out;
  bit          stall_rand;
  int          beat_cnt;
  int          words_in;
  int          words_exp;
  logic [31:0] data_seed;
  logic [31:0] ready_seed;

  realign_top u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_off_i   (cmd_off_i),
    .cmd_len_i   (cmd_len_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o),
    .out_strb_o  (out_strb_o),
    .out_last_o  (out_last_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      errors++;
      $display("ERR %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("timeout: %s", what);
  endtask

  // sink ready is about 30% low in random mode
  initial begin
    out_ready_i = 1'b1;
    ready_seed  = 32'h625c;
    forever begin
      @(posedge clk_i);
      #2;
      ready_seed  = lcg_next(ready_seed);
      out_ready_i = stall_rand ? ((ready_seed[31:16] % 10) >= 3) : 1'b1;
    end
  end

  // handshakes are sampled mid cycle and transfer on the next edge
  always @(negedge clk_i) begin
    if (rst_n_i && in_valid_i && in_ready_o) begin
      words_in++;
    end
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("output beat arrived with no expected beat pending");
      end else begin
        check_val("out_data_o", exp_data.pop_front(), out_data_o);
        check_val("out_strb_o", 32'(exp_strb.pop_front()), 32'(out_strb_o));
        check_val("out_last_o", 32'(exp_last.pop_front()), 32'(out_last_o));
        beat_cnt++;
        if (out_last_o) begin
          if (exp_cnt.size() == 0) begin
            errors++;
            $display("last beat seen with no command pending");
          end else begin
            check_val("out_beats", 32'(exp_cnt.pop_front()), 32'(beat_cnt));
          end
          beat_cnt = 0;
        end
      end
    end
  end

  // output beat j lane b carries payload byte j*NB+b-off
  task automatic build_expected(input int off, input int len, input int nbeats,
                                ref logic [31:0] words[$]);
    int            idx;
    logic [31:0]   data;
    logic [NB-1:0] strb;
    for (int j = 0; j < nbeats; j++) begin
      data = '0;
      strb = '0;
      for (int b = 0; b < NB; b++) begin
        idx = j * NB + b - off;
        if (idx >= 0 && idx < len) begin
          strb[b]       = 1'b1;
          data[8*b +: 8] = words[idx / NB][8*(idx % NB) +: 8];
        end
      end
      exp_data.push_back(data);
      exp_strb.push_back(strb);
      exp_last.push_back(j == nbeats - 1);
    end
    exp_cnt.push_back(nbeats);
  endtask

  task automatic send_cmd(input int off, input int len);
    int cnt;
    cnt         = 0;
    cmd_valid_i = 1'b1;
    cmd_off_i   = `REALIGN_OFF_W'(off);
    cmd_len_i   = `REALIGN_LEN_W'(len);
    @(negedge clk_i);
    while (!cmd_ready_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!cmd_ready_o) begin
      note_timeout("command was never accepted");
    end
    @(posedge clk_i);
    #2;
    cmd_valid_i = 1'b0;
  endtask

  task automatic send_word(input logic [31:0] word);
    int cnt;
    cnt        = 0;
    in_valid_i = 1'b1;
    in_data_i  = word;
    @(negedge clk_i);
    while (!in_ready_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!in_ready_o) begin
      note_timeout("input word was never accepted");
    end
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
    in_data_i  = '0;
  endtask

  task automatic run_row(input int r);
    logic [31:0] words[$];
    stall_rand = row_rand[r];
    // bytes past the length in the last word are random too
    for (int w = 0; w < row_words[r]; w++) begin
      data_seed = lcg_next(data_seed);
      words.push_back(data_seed);
    end
    words_exp += row_words[r];
    build_expected(row_off[r], row_len[r], row_beats[r], words);
    send_cmd(row_off[r], row_len[r]);
    for (int w = 0; w < words.size() && !timed_out; w++) begin
      send_word(words[w]);
    end
  endtask

  initial begin
    int cnt;
    errors      = 0;
    timed_out   = 1'b0;
    stall_rand  = 1'b0;
    beat_cnt    = 0;
    words_in    = 0;
    words_exp   = 0;
    data_seed   = 32'h625c;
    rst_n_i     = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_off_i   = '0;
    cmd_len_i   = '0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;

    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_val("cmd_ready_o", 32'd0, 32'(cmd_ready_o));
    check_val("in_ready_o", 32'd0, 32'(in_ready_o));
    check_val("out_valid_o", 32'd0, 32'(out_valid_o));
    @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    // nothing may come out while idle
    repeat (4) begin
      @(negedge clk_i);
      check_val("out_valid_o", 32'd0, 32'(out_valid_o));
      check_val("in_ready_o", 32'd0, 32'(in_ready_o));
    end
    @(posedge clk_i);
    #2;

    // rows go back to back with no drain in between
    for (int r = 0; r < N_ROWS && !timed_out; r++) begin
      run_row(r);
    end

    if (!timed_out) begin
      cnt = 0;
      while (exp_data.size() != 0 && cnt < 10 * TIMEOUT) begin
        @(negedge clk_i);
        cnt++;
      end
      if (exp_data.size() != 0) begin
        note_timeout("expected output beats never arrived");
      end
    end

    if (!timed_out) begin
      // a spare word with no command behind it must stay unconsumed
      @(posedge clk_i);
      #2;
      data_seed  = lcg_next(data_seed);
      in_valid_i = 1'b1;
      in_data_i  = data_seed;
      repeat (4) begin
        @(negedge clk_i);
        check_val("out_valid_o", 32'd0, 32'(out_valid_o));
        check_val("in_ready_o", 32'd0, 32'(in_ready_o));
      end
      @(posedge clk_i);
      #2;
      in_valid_i = 1'b0;
      in_data_i  = '0;
      check_val("in_words", 32'(words_exp), 32'(words_in));
    end

    $display("error count %0d", errors);
    if (errors == 0 && !timed_out) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verilog/realign_cmd_decode.sv */
// realign command sequencer
`timescale 1ns/1ps
`include "realign_consts.svh"

module realign_cmd_decode (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  realign_pkg::cmd_t      cmd_i,
  output logic                   ctl_valid_o,
  input  logic                   ctl_ready_i,
  output realign_pkg::beat_ctrl_t ctl_o
);

  import realign_pkg::*;

  localparam int NB = `REALIGN_NB;
  localparam int LW = `REALIGN_LEN_W;

  cmd_t          cmd_q;
  logic          busy_q;
  logic [LW-1:0] nbeats_q;
  logic [LW-1:0] npops_q;
  logic [LW-1:0] beat_cnt_q;
  logic [LW-1:0] pop_cnt_q;
  logic [LW-1:0] cmd_end;
  logic [LW-1:0] cur_end;
  logic [LW:0]   pos;
  logic          cmd_fire;
  logic          ctl_fire;

  // one command at a time, idle cycle after the last beat
  assign cmd_ready_o = ~busy_q;
  assign ctl_valid_o = busy_q;
  assign cmd_fire    = cmd_valid_i & cmd_ready_o;
  assign ctl_fire    = ctl_valid_o & ctl_ready_i;

  // end position of the incoming and the held command
  assign cmd_end = LW'(cmd_i.off) + cmd_i.len;
  assign cur_end = LW'(cmd_q.off) + cmd_q.len;

  // first output byte position of the current beat
  assign pos = (LW + 1)'(beat_cnt_q) * (LW + 1)'(NB);

  assign ctl_o.pop   = (pop_cnt_q < npops_q);
  assign ctl_o.first = (beat_cnt_q == '0);
  assign ctl_o.last  = (beat_cnt_q == nbeats_q - 1'b1);
  assign ctl_o.off   = cmd_q.off;

  // byte lane valid when it falls inside off .. off+len-1
  always_comb begin
    logic [LW:0] idx;
    for (int b = 0; b < NB; b++) begin
      idx = pos + (LW + 1)'(b);
      ctl_o.strb[b] = (idx >= (LW + 1)'(cmd_q.off)) && (idx < (LW + 1)'(cur_end));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      beat_cnt_q <= '0;
      pop_cnt_q  <= '0;
    end else if (cmd_fire) begin
      busy_q     <= 1'b1;
      beat_cnt_q <= '0;
      pop_cnt_q  <= '0;
    end else if (ctl_fire) begin
      if (ctl_o.last) begin
        busy_q <= 1'b0;
      end
      beat_cnt_q <= beat_cnt_q + 1'b1;
      if (ctl_o.pop) begin
        pop_cnt_q <= pop_cnt_q + 1'b1;
      end
    end
  end

  // beat and word totals, ceil((off+len)/NB) and ceil(len/NB)
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      cmd_q    <= cmd_i;
      nbeats_q <= LW'((cmd_end + LW'(NB - 1)) / NB);
      npops_q  <= LW'((cmd_i.len + LW'(NB - 1)) / NB);
    end
  end

  a_pop_le_beat : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_cnt_q <= beat_cnt_q);

  a_cmd_len : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_fire |-> (cmd_i.len != '0) && (cmd_i.len <= LW'(`REALIGN_MAX_LEN)));

  // every input word of the command is consumed by its last beat
  a_pops_done : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctl_fire && ctl_o.last |=> pop_cnt_q == npops_q);

endmodule

/* verilog/realign_consts.svh */
// realign sizing constants
`ifndef REALIGN_CONSTS_SVH
`define REALIGN_CONSTS_SVH

// bytes per stream word
`define REALIGN_NB 4

// stream data width in bits
`define REALIGN_DW (`REALIGN_NB * 8)

// offset field width, log2 of the word bytes
`define REALIGN_OFF_W 2

// longest transfer in bytes and the length field that holds it
`define REALIGN_MAX_LEN 64
`define REALIGN_LEN_W 7

// buffer depths
`define REALIGN_CMD_DEPTH 2
`define REALIGN_OUT_DEPTH 4

`endif

/* verilog/realign_pkg.sv */
// realign stream types
`include "realign_consts.svh"

package realign_pkg;

  // one transfer request
  typedef struct packed {
    logic [`REALIGN_OFF_W-1:0] off;
    logic [`REALIGN_LEN_W-1:0] len;
  } cmd_t;

  // control for a single output beat, decode to execute
  typedef struct packed {
    logic                      pop;
    logic                      first;
    logic                      last;
    logic [`REALIGN_OFF_W-1:0] off;
    logic [`REALIGN_NB-1:0]    strb;
  } beat_ctrl_t;

  // one realigned output beat
  typedef struct packed {
    logic [`REALIGN_DW-1:0] data;
    logic [`REALIGN_NB-1:0] strb;
    logic                   last;
  } beat_t;

endpackage

/* verilog/realign_shift_exec.sv */
// realign shift datapath
`timescale 1ns/1ps
`include "realign_consts.svh"

module realign_shift_exec (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    ctl_valid_i,
  output logic                    ctl_ready_o,
  input  realign_pkg::beat_ctrl_t ctl_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic [`REALIGN_DW-1:0]  in_data_i,
  output logic                    beat_valid_o,
  input  logic                    beat_ready_i,
  output realign_pkg::beat_t      beat_o
);

  import realign_pkg::*;

  localparam int NB = `REALIGN_NB;
  localparam int DW = `REALIGN_DW;

  beat_t           beat_q;
  logic            beat_valid_q;
  logic [DW-1:0]   prev_q;
  logic [DW-1:0]   prev_word;
  logic [DW-1:0]   cur_word;
  logic [2*DW-1:0] both;
  logic [DW-1:0]   shifted;
  logic [DW-1:0]   masked;
  logic            space;
  logic            ctl_fire;

  // output register empty or draining this cycle
  assign space = ~beat_valid_q | beat_ready_i;

  // a pop control also needs an input word
  assign in_ready_o  = ctl_valid_i & ctl_i.pop & space;
  assign ctl_ready_o = space & (~ctl_i.pop | in_valid_i);
  assign ctl_fire    = ctl_valid_i & ctl_ready_o;

  // the drain beat has no new word and the first beat no old one
  assign cur_word  = ctl_i.pop ? in_data_i : '0;
  assign prev_word = ctl_i.first ? '0 : prev_q;

  // lanes below off come from the old word and the rest from the new one
  assign both    = {cur_word, prev_word};
  assign shifted = DW'(both >> (8 * (NB - int'(ctl_i.off))));

  always_comb begin
    for (int b = 0; b < NB; b++) begin
      masked[8*b +: 8] = ctl_i.strb[b] ? shifted[8*b +: 8] : 8'h00;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_valid_q <= 1'b0;
    end else if (ctl_fire) begin
      beat_valid_q <= 1'b1;
    end else if (beat_ready_i) begin
      beat_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctl_fire) begin
      beat_q.data <= masked;
      beat_q.strb <= ctl_i.strb;
      beat_q.last <= ctl_i.last;
    end
    // keep the consumed word for the next beat's low lanes
    if (ctl_fire && ctl_i.pop) begin
      prev_q <= in_data_i;
    end
  end

  assign beat_valid_o = beat_valid_q;
  assign beat_o       = beat_q;

  a_in_ready_pop : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_ready_o |-> ctl_valid_i && ctl_i.pop);

  // a stalled control from decode holds until taken
  a_ctl_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctl_valid_i && !ctl_ready_o |=> ctl_valid_i && $stable(ctl_i));

endmodule

/* verilog/realign_top.sv */
// sink side byte realigner
`timescale 1ns/1ps
`include "realign_consts.svh"

module realign_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     cmd_valid_i,
  output logic                     cmd_ready_o,
  input  logic [`REALIGN_OFF_W-1:0] cmd_off_i,
  input  logic [`REALIGN_LEN_W-1:0] cmd_len_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic [`REALIGN_DW-1:0]   in_data_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic [`REALIGN_DW-1:0]   out_data_o,
  output logic [`REALIGN_NB-1:0]   out_strb_o,
  output logic                     out_last_o
);

  import realign_pkg::*;

  cmd_t       cmd_in;
  cmd_t       cmd_head;
  logic       cmd_head_valid;
  logic       cmd_head_ready;
  beat_ctrl_t ctl;
  logic       ctl_valid;
  logic       ctl_ready;
  beat_t      beat;
  logic       beat_valid;
  logic       beat_ready;
  beat_t      out_beat;

  assign cmd_in.off = cmd_off_i;
  assign cmd_in.len = cmd_len_i;

  stream_fifo #(
    .payload_t (cmd_t),
    .DEPTH     (`REALIGN_CMD_DEPTH)
  ) u_cmd_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (cmd_valid_i),
    .push_ready_o (cmd_ready_o),
    .push_data_i  (cmd_in),
    .pop_valid_o  (cmd_head_valid),
    .pop_ready_i  (cmd_head_ready),
    .pop_data_o   (cmd_head)
  );

  realign_cmd_decode u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_head_valid),
    .cmd_ready_o (cmd_head_ready),
    .cmd_i       (cmd_head),
    .ctl_valid_o (ctl_valid),
    .ctl_ready_i (ctl_ready),
    .ctl_o       (ctl)
  );

  realign_shift_exec u_exec (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ctl_valid_i  (ctl_valid),
    .ctl_ready_o  (ctl_ready),
    .ctl_i        (ctl),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_data_i    (in_data_i),
    .beat_valid_o (beat_valid),
    .beat_ready_i (beat_ready),
    .beat_o       (beat)
  );

  // result stage, output beat buffer
  stream_fifo #(
    .payload_t (beat_t),
    .DEPTH     (`REALIGN_OUT_DEPTH)
  ) u_out_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (beat_valid),
    .push_ready_o (beat_ready),
    .push_data_i  (beat),
    .pop_valid_o  (out_valid_o),
    .pop_ready_i  (out_ready_i),
    .pop_data_o   (out_beat)
  );

  assign out_data_o = out_beat.data;
  assign out_strb_o = out_beat.strb;
  assign out_last_o = out_beat.last;

endmodule

/* verilog/stream_fifo.sv */
// valid/ready stream FIFO
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_next;
  logic             ready_q;
  logic             push_fire;
  logic             pop_fire;

  assign push_fire = push_valid_i & push_ready_o;
  assign pop_fire  = pop_valid_o & pop_ready_i;

  // not full, registered so it stays low while in reset
  assign push_ready_o = ready_q;
  assign pop_valid_o  = (cnt_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  always_comb begin
    cnt_next = cnt_q;
    if (push_fire && !pop_fire) begin
      cnt_next = cnt_q + 1'b1;
    end else if (pop_fire && !push_fire) begin
      cnt_next = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      ready_q  <= 1'b0;
    end else begin
      cnt_q   <= cnt_next;
      ready_q <= (cnt_next != CNT_W'(DEPTH));
      if (push_fire) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  a_cnt_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= CNT_W'(DEPTH));

  // head entry holds while the consumer stalls
  a_pop_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_valid_o && !pop_ready_i |=> pop_valid_o && $stable(pop_data_o));

endmodule
